// File: verilog.f
rtl/csr_pkg.sv
rtl/csr_field_reg.sv
rtl/csr_decode.sv
rtl/csr_trap_ctrl.sv
rtl/csr_machine.sv
rtl/csr_top.sv
dv/csr_asserts.sv
dv/csr_checker.sv
dv/csr_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f verilog.f --top-module csr_tb -Mdir obj_dir -o csr_sim

run: compile
	@out="$$(./obj_dir/csr_sim)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: dv/csr_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csr_tb
    import csr_pkg::*;
;

    localparam int N_INSTR = 40 + 230 + 40 + 60 + 430;          // Cycles driven per test, summed
    localparam int LIMIT   = N_INSTR * 4 + 100;

    logic      clk, reset_n, csr_valid, ebreak;
    logic      irq_external, irq_timer, irq_soft;
    csr_op_e   csr_op;
    csr_addr_t csr_addr;
    csr_data_t csr_operand, pc;
    logic      rdata_valid, trap_valid;
    csr_data_t rdata, trap_pc, ret_addr;
    int        cycles;
    csr_addr_t rand_addr;
    csr_data_t irq_pc;                              // PC held while an interrupt is taken

    csr_addr_t rw_addrs[8] = '{12'h300, 12'h304, 12'h305, 12'h306,
                               12'h340, 12'h341, 12'h342, 12'h343};
    csr_addr_t all_addrs[16] = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h306, 12'h310,
                                 12'h340, 12'h341, 12'h342, 12'h343, 12'h344, 12'h302,
                                 12'h3ff, 12'h740, 12'hb00, 12'hf05};

    csr_top dut0 (
        .i_clk(clk), .i_reset_n(reset_n), .i_csr_valid(csr_valid), .i_csr_op(csr_op),
        .i_csr_addr(csr_addr), .i_csr_operand(csr_operand), .i_ebreak(ebreak), .i_pc(pc),
        .i_irq_external(irq_external), .i_irq_timer(irq_timer), .i_irq_soft(irq_soft),
        .o_rdata_valid(rdata_valid), .o_rdata(rdata), .o_trap_valid(trap_valid),
        .o_trap_pc(trap_pc), .o_ret_addr(ret_addr)
    );

    csr_checker chk0 (
        .i_clk(clk), .i_reset_n(reset_n), .i_csr_valid(csr_valid), .i_csr_op(csr_op),
        .i_csr_addr(csr_addr), .i_csr_operand(csr_operand), .i_ebreak(ebreak), .i_pc(pc),
        .i_irq_external(irq_external), .i_irq_timer(irq_timer), .i_irq_soft(irq_soft),
        .i_rdata_valid(rdata_valid), .i_rdata(rdata), .i_trap_valid(trap_valid),
        .i_trap_pc(trap_pc), .i_ret_addr(ret_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // One cycle of stimulus, changed shortly after the rising edge
    task automatic drive_cycle(input logic v, input csr_op_e op, input csr_addr_t a,
                               input csr_data_t d, input logic brk, input csr_data_t p);
        @(posedge clk);
        #2;
        csr_valid   = v;
        csr_op      = op;
        csr_addr    = a;
        csr_operand = d;
        ebreak      = brk;
        pc          = p;
    endtask

    task automatic csr_instr(input csr_op_e op, input csr_addr_t a, input csr_data_t d);
        drive_cycle(1'b1, op, a, d, 1'b0, '0);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, CSR_OP_NONE, '0, '0, 1'b0, '0);
    endtask

    initial
    begin
        void'($urandom(32'h0ae8d1b4));
        cycles = 0;
        {reset_n, csr_valid, ebreak, irq_external, irq_timer, irq_soft} = '0;
        csr_op = CSR_OP_NONE;
        csr_addr = '0;
        csr_operand = '0;
        pc = '0;
        repeat (5) @(posedge clk);
        #2 reset_n = 1'b1;

        for (int i = 0; i < 16; i++)                // Reset values and unmapped space
            csr_instr(CSR_OP_NONE, all_addrs[i], '0);
        for (int i = 11; i < 16; i++)
            csr_instr(CSR_OP_RW, all_addrs[i], 32'hffff_ffff);
        irq_external = 1'b1;                        // mip sees MEIP and MTIP
        irq_timer    = 1'b1;
        csr_instr(CSR_OP_NONE, 12'h344, '0);
        csr_instr(CSR_OP_NONE, 12'h340, '0);
        idle(4);
        {irq_external, irq_timer} = '0;
        chk0.report_test("reset_values");

        for (int i = 0; i < 200; i++)               // Back-to-back with rare gaps
        begin
            if ($urandom % 10 == 0)
                idle(1);
            csr_instr(csr_op_e'($urandom % 4), rw_addrs[$urandom % 8],
                      ($urandom % 8 == 0) ? 32'd0 : $urandom);
        end
        csr_instr(CSR_OP_RW, 12'h300, '0);          // Interrupts stay off
        idle(4);
        chk0.report_test("read_write_set_clear");

        for (int i = 0; i < 4; i++)
        begin
            csr_instr(CSR_OP_RW, 12'h305, (i < 2) ? 32'h1000_0100 : 32'h2000_0201);
            drive_cycle(1'b0, CSR_OP_NONE, '0, '0, 1'b1, $urandom);
            idle(2);
            csr_instr(CSR_OP_NONE, 12'h341, '0);
            csr_instr(CSR_OP_NONE, 12'h342, '0);
            csr_instr(CSR_OP_NONE, 12'h300, '0);
        end
        idle(4);
        chk0.report_test("ebreak");

        csr_instr(CSR_OP_RW, 12'h305, 32'h0000_8001);   // Vectored
        csr_instr(CSR_OP_RW, 12'h304, 32'h0000_0888);
        for (int i = 0; i < 4; i++)
        begin
            irq_external = (i == 0);
            irq_soft     = (i <= 1);
            irq_timer    = (i <= 2);
            irq_pc       = $urandom;
            csr_instr(CSR_OP_SET, 12'h300, 32'h0000_0008);
            repeat (3) drive_cycle(1'b0, CSR_OP_NONE, '0, '0, 1'b0, irq_pc);
            csr_instr(CSR_OP_NONE, 12'h300, '0);
            csr_instr(CSR_OP_NONE, 12'h342, '0);
            {irq_external, irq_soft, irq_timer} = '0;
            idle(2);
        end
        csr_instr(CSR_OP_RW, 12'h300, '0);
        idle(4);
        chk0.report_test("interrupts");

        for (int i = 0; i < 400; i++)               // Mixed traffic with traps
        begin
            if ($urandom % 10 < 7)
                rand_addr = all_addrs[$urandom % 11];
            else
                rand_addr = all_addrs[$urandom % 16];
            drive_cycle(1'($urandom % 10 < 7), csr_op_e'($urandom % 4), rand_addr, $urandom,
                        1'($urandom % 16 == 0), $urandom);
            if ($urandom % 8 == 0)
                {irq_external, irq_soft, irq_timer} = 3'($urandom);
        end
        {irq_external, irq_soft, irq_timer} = '0;
        csr_instr(CSR_OP_RW, 12'h300, '0);
        idle(4);
        chk0.report_test("random_mix");

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 chk0.check_count, chk0.err_count, dut0.asr0.fail_count);
        if (chk0.err_count == 0 && dut0.asr0.fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/csr_checker.sv
`timescale 1ns/100ps
`default_nettype none

module csr_checker
    import csr_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_reset_n,
    input  wire logic  i_csr_valid,
    input  csr_op_e    i_csr_op,
    input  csr_addr_t  i_csr_addr,
    input  csr_data_t  i_csr_operand,
    input  wire logic  i_ebreak,
    input  csr_data_t  i_pc,
    input  wire logic  i_irq_external,
    input  wire logic  i_irq_timer,
    input  wire logic  i_irq_soft,
    input  wire logic  i_rdata_valid,
    input  csr_data_t  i_rdata,
    input  wire logic  i_trap_valid,
    input  csr_data_t  i_trap_pc,
    input  csr_data_t  i_ret_addr
);

    int          err_count;
    int          check_count;
    int          err_mark;

    logic [31:0] m_mstatus, m_mie, m_mtvec, m_mcounteren;  // Model CSR state
    logic [31:0] m_mscratch, m_mepc, m_mcause, m_mtval;
    logic        d_valid;                           // Instruction in the file stage
    logic [1:0]  d_op;
    logic [11:0] d_addr;
    logic [31:0] d_data;
    logic        trap_d;                            // Trap strobe now on the outputs
    logic        trap_int_d;
    logic [7:0]  trap_code_d;
    logic [31:0] trap_pc_d;
    logic        exp_valid;                         // Read result now on the outputs
    logic [31:0] exp_rdata;

    initial
    begin
        err_count   = 0;
        check_count = 0;
        err_mark    = 0;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERROR %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs     = err_count - err_mark;
        err_mark = err_count;
        $display("Test %s: %0d errors, %s", name, errs, (errs == 0) ? "ok" : "wrong values");
    endtask

    // Write, set or clear applied to the implemented bits only
    function automatic logic [31:0] apply_op(input logic [31:0] old, input logic [1:0] op,
                                             input logic [31:0] d, input logic [31:0] mask);
        logic [31:0] r;
        case (op)
            2'd1:    r = d;
            2'd2:    r = old | d;
            2'd3:    r = old & ~d;
            default: r = old;
        endcase
        return r & mask;
    endfunction

    function automatic logic [31:0] read_csr(input logic [11:0] addr);
        if (addr[11:8] != 4'h3)
            return 32'd0;                           // Outside the machine block
        case (addr[7:0])
            8'h00:   return m_mstatus;
            8'h01:   return 32'h4000_0104;          // RV32, I and C
            8'h04:   return m_mie;
            8'h05:   return m_mtvec;
            8'h06:   return m_mcounteren;
            8'h40:   return m_mscratch;
            8'h41:   return m_mepc;
            8'h42:   return m_mcause;
            8'h43:   return m_mtval;
            8'h44:   return {20'd0, i_irq_external, 3'd0, i_irq_timer, 3'd0, i_irq_soft, 3'd0};
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] trap_target(input logic [31:0] tvec, input logic is_int,
                                                input logic [7:0] code);
        if (tvec[1:0] == 2'b01 && is_int)
            return {tvec[31:2], 2'b00} + {22'd0, code, 2'b00};
        return {tvec[31:2], 2'b00};
    endfunction

    always @(posedge i_clk)
    begin
        logic        fire;
        logic        s_mie;
        logic [2:0]  en;
        logic [31:0] rd;
        if (!i_reset_n)
        begin
            {m_mstatus, m_mie, m_mtvec, m_mcounteren} = '0;
            {m_mscratch, m_mepc, m_mcause, m_mtval}   = '0;
            {d_valid, trap_d, exp_valid}              = '0;
        end
        else
        begin
            // Outputs of the cycle that just ended
            compare("o_rdata_valid", {31'd0, i_rdata_valid}, {31'd0, exp_valid});
            if (exp_valid)
                compare("o_rdata", i_rdata, exp_rdata);
            compare("o_trap_valid", {31'd0, i_trap_valid}, {31'd0, trap_d});
            if (trap_d)
                compare("o_trap_pc", i_trap_pc, trap_target(m_mtvec, trap_int_d, trap_code_d));
            compare("o_ret_addr", i_ret_addr, m_mepc);

            s_mie = m_mstatus[3];
            en    = {i_irq_external & m_mie[11], i_irq_soft & m_mie[3], i_irq_timer & m_mie[7]};
            fire  = !trap_d && (i_ebreak || (s_mie && (en != 3'd0)));

            rd = read_csr(d_addr);
            if (d_valid && d_addr[11:8] == 4'h3)
            begin
                case (d_addr[7:0])
                    8'h00: m_mstatus    = apply_op(m_mstatus, d_op, d_data, 32'h0000_0088);
                    8'h04: m_mie        = apply_op(m_mie, d_op, d_data, 32'h0000_0fff);
                    8'h05: m_mtvec      = apply_op(m_mtvec, d_op, d_data, 32'hffff_ffff);
                    8'h06: m_mcounteren = apply_op(m_mcounteren, d_op, d_data, 32'h0000_0007);
                    8'h40: m_mscratch   = apply_op(m_mscratch, d_op, d_data, 32'hffff_ffff);
                    8'h41: m_mepc       = apply_op(m_mepc, d_op, d_data, 32'hffff_ffff);
                    8'h42: m_mcause     = apply_op(m_mcause, d_op, d_data, 32'h8000_00ff);
                    8'h43: m_mtval      = apply_op(m_mtval, d_op, d_data, 32'hffff_ffff);
                    default: ;
                endcase
            end
            if (trap_d)                             // Capture beats the CSR write
            begin
                m_mstatus = s_mie ? 32'h0000_0080 : 32'h0;
                m_mepc    = trap_pc_d;
                m_mcause  = {trap_int_d, 23'd0, trap_code_d};
            end
            exp_valid = d_valid;
            exp_rdata = rd;

            if (fire)
            begin
                trap_int_d  = !i_ebreak;
                trap_code_d = i_ebreak ? 8'd3 : en[2] ? 8'd11 : en[1] ? 8'd3 : 8'd7;
                trap_pc_d   = i_pc;
            end
            trap_d  = fire;
            d_valid = i_csr_valid;
            d_op    = i_csr_op;
            d_addr  = i_csr_addr;
            d_data  = i_csr_operand;
        end
    end

endmodule

`default_nettype wire

// File: dv/csr_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module csr_asserts
(
    input  wire logic i_clk,
    input  wire logic i_reset_n,
    input  wire logic i_csr_valid,
    input  wire logic i_dec_write,
    input  wire logic i_dec_set,
    input  wire logic i_dec_clear,
    input  wire logic i_rdata_valid,
    input  wire logic i_trap_valid
);

    int fail_count;                                 // Failed assertions so far

    initial
    begin
        fail_count = 0;
    end

    // Read data comes back exactly two cycles after the instruction
    a_rdata_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_rdata_valid == $past(i_csr_valid, 2))
        else
        begin
            $error("o_rdata_valid does not follow i_csr_valid by two cycles");
            fail_count++;
        end

    a_write_kind: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $onehot0({i_dec_write, i_dec_set, i_dec_clear}))
        else
        begin
            $error("More than one decode write-kind strobe is high");
            fail_count++;
        end

    a_trap_gap: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_trap_valid && $past(i_trap_valid)))
        else
        begin
            $error("Two consecutive trap strobes");
            fail_count++;
        end

endmodule

bind csr_top csr_asserts asr0 (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_csr_valid   (i_csr_valid),
    .i_dec_write   (dec_write),
    .i_dec_set     (dec_set),
    .i_dec_clear   (dec_clear),
    .i_rdata_valid (o_rdata_valid),
    .i_trap_valid  (o_trap_valid)
);

`default_nettype wire

// File: rtl/csr_top.sv
`timescale 1ns/100ps
`default_nettype none

module csr_top
    import csr_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset_n,
    input  wire logic      i_csr_valid,
    input  csr_op_e        i_csr_op,
    input  csr_addr_t      i_csr_addr,
    input  csr_data_t      i_csr_operand,
    input  wire logic      i_ebreak,
    input  csr_data_t      i_pc,
    input  wire logic      i_irq_external,
    input  wire logic      i_irq_timer,
    input  wire logic      i_irq_soft,
    output logic           o_rdata_valid,
    output csr_data_t      o_rdata,
    output logic           o_trap_valid,
    output csr_data_t      o_trap_pc,
    output csr_data_t      o_ret_addr
);

    logic        dec_sel;                           // Decode to CSR file
    logic        dec_read;
    logic        dec_write;
    logic        dec_set;
    logic        dec_clear;
    csr_idx_t    dec_idx;
    csr_data_t   dec_data;

    irq_mask_t   mie_q;                             // CSR file to trap stage
    logic        mstatus_mie_q;

    logic        trap_valid;                        // Trap stage to CSR file
    logic        trap_is_int;
    cause_code_t trap_code;
    csr_data_t   trap_pc;

    csr_decode u_decode (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_csr_valid   (i_csr_valid),
        .i_csr_op      (i_csr_op),
        .i_csr_addr    (i_csr_addr),
        .i_csr_operand (i_csr_operand),
        .o_sel         (dec_sel),
        .o_read        (dec_read),
        .o_write       (dec_write),
        .o_set         (dec_set),
        .o_clear       (dec_clear),
        .o_idx         (dec_idx),
        .o_data        (dec_data)
    );

    csr_trap_ctrl u_trap_ctrl (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_ebreak       (i_ebreak),
        .i_pc           (i_pc),
        .i_irq_external (i_irq_external),
        .i_irq_timer    (i_irq_timer),
        .i_irq_soft     (i_irq_soft),
        .i_mie          (mie_q),
        .i_mstatus_mie  (mstatus_mie_q),
        .o_trap_valid   (trap_valid),
        .o_trap_is_int  (trap_is_int),
        .o_trap_code    (trap_code),
        .o_trap_pc      (trap_pc)
    );

    csr_machine u_machine (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_sel          (dec_sel),
        .i_read         (dec_read),
        .i_write        (dec_write),
        .i_set          (dec_set),
        .i_clear        (dec_clear),
        .i_idx          (dec_idx),
        .i_data         (dec_data),
        .i_irq_external (i_irq_external),
        .i_irq_timer    (i_irq_timer),
        .i_irq_soft     (i_irq_soft),
        .i_trap_valid   (trap_valid),
        .i_trap_is_int  (trap_is_int),
        .i_trap_code    (trap_code),
        .i_trap_pc      (trap_pc),
        .o_mie          (mie_q),
        .o_mstatus_mie  (mstatus_mie_q),
        .o_rdata_valid  (o_rdata_valid),
        .o_rdata        (o_rdata),
        .o_trap_valid   (o_trap_valid),
        .o_trap_pc      (o_trap_pc),
        .o_ret_addr     (o_ret_addr)
    );

endmodule

`default_nettype wire

// File: rtl/csr_machine.sv
`timescale 1ns/100ps
`default_nettype none

module csr_machine
    import csr_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset_n,
    input  wire logic      i_sel,
    input  wire logic      i_read,
    input  wire logic      i_write,
    input  wire logic      i_set,
    input  wire logic      i_clear,
    input  csr_idx_t       i_idx,
    input  csr_data_t      i_data,
    input  wire logic      i_irq_external,
    input  wire logic      i_irq_timer,
    input  wire logic      i_irq_soft,
    input  wire logic      i_trap_valid,
    input  wire logic      i_trap_is_int,
    input  cause_code_t    i_trap_code,
    input  csr_data_t      i_trap_pc,
    output irq_mask_t      o_mie,
    output logic           o_mstatus_mie,
    output logic           o_rdata_valid,
    output csr_data_t      o_rdata,
    output logic           o_trap_valid,
    output csr_data_t      o_trap_pc,
    output csr_data_t      o_ret_addr
);

    logic        sel_mstatus;
    logic        sel_mie;
    logic        sel_mtvec;
    logic        sel_mcounteren;
    logic        sel_mscratch;
    logic        sel_mepc;
    logic        sel_mcause;
    logic        sel_mtval;

    csr_data_t   mie_data;
    csr_data_t   mtvec_data;
    csr_data_t   mcounteren_data;
    csr_data_t   mscratch_data;
    csr_data_t   mtval_data;

    logic        mstatus_mie_q;
    logic        mstatus_mpie_q;
    csr_data_t   mepc_q;
    logic        mcause_int_q;                      // mcause bit 31
    cause_code_t mcause_code_q;

    csr_data_t   mstatus_data;
    csr_data_t   mcause_data;
    csr_data_t   mstatus_nxt;
    csr_data_t   mcause_nxt;
    csr_data_t   mepc_nxt;
    irq_mask_t   mip_data;
    csr_data_t   rd_mux;
    csr_data_t   tvec_base;
    csr_data_t   tvec_vect;

    // Result of a write, set or clear on a register held here
    function automatic csr_data_t apply_op(input csr_data_t old_val, input logic sel);
        csr_data_t res;
        res = old_val;
        if (sel && i_write)
            res = i_data;
        else if (sel && i_set)
            res = old_val | i_data;
        else if (sel && i_clear)
            res = old_val & ~i_data;
        return res;
    endfunction

    assign sel_mstatus    = i_sel && (i_idx == IDX_MSTATUS);
    assign sel_mie        = i_sel && (i_idx == IDX_MIE);
    assign sel_mtvec      = i_sel && (i_idx == IDX_MTVEC);
    assign sel_mcounteren = i_sel && (i_idx == IDX_MCOUNTEREN);
    assign sel_mscratch   = i_sel && (i_idx == IDX_MSCRATCH);
    assign sel_mepc       = i_sel && (i_idx == IDX_MEPC);
    assign sel_mcause     = i_sel && (i_idx == IDX_MCAUSE);
    assign sel_mtval      = i_sel && (i_idx == IDX_MTVAL);

    csr_field_reg #(.WIDTH(12)) u_mie (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_sel(sel_mie),
        .i_write(i_write), .i_set(i_set), .i_clear(i_clear),
        .i_data(i_data), .o_data(mie_data)
    );
    csr_field_reg #(.WIDTH(32)) u_mtvec (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_sel(sel_mtvec),
        .i_write(i_write), .i_set(i_set), .i_clear(i_clear),
        .i_data(i_data), .o_data(mtvec_data)
    );
    csr_field_reg #(.WIDTH(3)) u_mcounteren (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_sel(sel_mcounteren),
        .i_write(i_write), .i_set(i_set), .i_clear(i_clear),
        .i_data(i_data), .o_data(mcounteren_data)
    );
    csr_field_reg #(.WIDTH(32)) u_mscratch (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_sel(sel_mscratch),
        .i_write(i_write), .i_set(i_set), .i_clear(i_clear),
        .i_data(i_data), .o_data(mscratch_data)
    );
    csr_field_reg #(.WIDTH(32)) u_mtval (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_sel(sel_mtval),
        .i_write(i_write), .i_set(i_set), .i_clear(i_clear),
        .i_data(i_data), .o_data(mtval_data)
    );

    always_comb
    begin
        mstatus_data = '0;                          // Only MIE and MPIE exist
        mstatus_data[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        mstatus_data[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
    end

    assign mcause_data = {mcause_int_q, 23'd0, mcause_code_q};
    assign mip_data    = {i_irq_external, 3'd0, i_irq_timer, 3'd0, i_irq_soft, 3'd0};

    assign mstatus_nxt = apply_op(mstatus_data, sel_mstatus);
    assign mcause_nxt  = apply_op(mcause_data, sel_mcause);
    assign mepc_nxt    = apply_op(mepc_q, sel_mepc);

    // Trap capture overrides a same-cycle CSR write
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mepc_q         <= '0;
            mcause_int_q   <= 1'b0;
            mcause_code_q  <= '0;
        end
        else if (i_trap_valid)
        begin
            mstatus_mpie_q <= mstatus_mie_q;        // Stack the enable
            mstatus_mie_q  <= 1'b0;
            mepc_q         <= i_trap_pc;
            mcause_int_q   <= i_trap_is_int;
            mcause_code_q  <= i_trap_code;
        end
        else
        begin
            mstatus_mie_q  <= mstatus_nxt[MSTATUS_MIE_BIT];
            mstatus_mpie_q <= mstatus_nxt[MSTATUS_MPIE_BIT];
            mepc_q         <= mepc_nxt;
            mcause_int_q   <= mcause_nxt[31];
            mcause_code_q  <= mcause_nxt[7:0];
        end
    end

    always_comb
    begin
        rd_mux = '0;                                // Unmapped reads zero
        if (i_sel)
        begin
            case (i_idx)
                IDX_MSTATUS:    rd_mux = mstatus_data;
                IDX_MISA:       rd_mux = MISA_VALUE;
                IDX_MIE:        rd_mux = mie_data;
                IDX_MTVEC:      rd_mux = mtvec_data;
                IDX_MCOUNTEREN: rd_mux = mcounteren_data;
                IDX_MSTATUSH:   rd_mux = '0;        // Little endian, no fields
                IDX_MSCRATCH:   rd_mux = mscratch_data;
                IDX_MEPC:       rd_mux = mepc_q;
                IDX_MCAUSE:     rd_mux = mcause_data;
                IDX_MTVAL:      rd_mux = mtval_data;
                IDX_MIP:        rd_mux = csr_data_t'(mip_data);
                default:        rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            o_rdata_valid <= 1'b0;
        else
            o_rdata_valid <= i_read;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_read)
            o_rdata <= rd_mux;                      // Value before this write
    end

    // Vectored mode applies to interrupts only, reserved modes use the base
    assign tvec_base = {mtvec_data[31:2], 2'b00};
    assign tvec_vect = tvec_base + (csr_data_t'(i_trap_code) << 2);

    assign o_trap_pc     = (mtvec_data[1:0] == 2'b01 && i_trap_is_int) ? tvec_vect : tvec_base;
    assign o_trap_valid  = i_trap_valid;
    assign o_ret_addr    = mepc_q;
    assign o_mie         = mie_data[11:0];
    assign o_mstatus_mie = mstatus_mie_q;

endmodule

`default_nettype wire

// File: rtl/csr_trap_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module csr_trap_ctrl
    import csr_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset_n,
    input  wire logic      i_ebreak,
    input  csr_data_t      i_pc,
    input  wire logic      i_irq_external,
    input  wire logic      i_irq_timer,
    input  wire logic      i_irq_soft,
    input  irq_mask_t      i_mie,
    input  wire logic      i_mstatus_mie,
    output logic           o_trap_valid,
    output logic           o_trap_is_int,
    output cause_code_t    o_trap_code,
    output csr_data_t      o_trap_pc
);

    logic        ext_en;                            // Pending and enabled
    logic        timer_en;
    logic        soft_en;
    logic        irq_take;
    logic        fire;
    logic        is_int_nxt;
    cause_code_t code_nxt;

    assign ext_en   = i_irq_external && i_mie[11];  // MEIE
    assign timer_en = i_irq_timer    && i_mie[7];   // MTIE
    assign soft_en  = i_irq_soft     && i_mie[3];   // MSIE

    assign irq_take = i_mstatus_mie && (ext_en || timer_en || soft_en);

    // MIE is still set while the strobe is out, so hold off one cycle
    assign fire = !o_trap_valid && (i_ebreak || irq_take);

    always_comb
    begin
        is_int_nxt = 1'b1;
        code_nxt   = CAUSE_M_TIMER;
        if (i_ebreak)
        begin
            is_int_nxt = 1'b0;                      // Exception beats interrupts
            code_nxt   = CAUSE_BREAKPOINT;
        end
        else if (ext_en)
            code_nxt = CAUSE_M_EXT;
        else if (soft_en)
            code_nxt = CAUSE_M_SOFT;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            o_trap_valid <= 1'b0;
        else
            o_trap_valid <= fire;
    end

    always_ff @(posedge i_clk)
    begin
        if (fire)
        begin
            o_trap_is_int <= is_int_nxt;
            o_trap_code   <= code_nxt;
            o_trap_pc     <= i_pc;                  // Becomes mepc
        end
    end

endmodule

`default_nettype wire

// File: rtl/csr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset_n,
    input  wire logic      i_csr_valid,
    input  csr_op_e        i_csr_op,
    input  csr_addr_t      i_csr_addr,
    input  csr_data_t      i_csr_operand,
    output logic           o_sel,
    output logic           o_read,
    output logic           o_write,
    output logic           o_set,
    output logic           o_clear,
    output csr_idx_t       o_idx,
    output csr_data_t      o_data
);

    logic in_block;                                 // Address in 0x3xx
    logic operand_zero;                             // Set/clear has no effect
    logic write_nxt;
    logic set_nxt;
    logic clear_nxt;

    assign in_block     = (i_csr_addr[11:8] == CSR_ADDR_HI);
    assign operand_zero = (i_csr_operand == '0);

    always_comb
    begin
        write_nxt = 1'b0;
        set_nxt   = 1'b0;
        clear_nxt = 1'b0;
        if (i_csr_valid)
        begin
            case (i_csr_op)
                CSR_OP_RW:    write_nxt = 1'b1;
                CSR_OP_SET:   set_nxt   = !operand_zero;   // csrrs x0 style read
                CSR_OP_CLEAR: clear_nxt = !operand_zero;
                default:      write_nxt = 1'b0;            // Plain read
            endcase
        end
    end

    // Control strobes of the first stage
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_sel   <= 1'b0;
            o_read  <= 1'b0;
            o_write <= 1'b0;
            o_set   <= 1'b0;
            o_clear <= 1'b0;
        end
        else
        begin
            o_sel   <= i_csr_valid && in_block;
            o_read  <= i_csr_valid;                 // Read slot even if unmapped
            o_write <= write_nxt;
            o_set   <= set_nxt;
            o_clear <= clear_nxt;
        end
    end

    // Payload travels alongside the strobes
    always_ff @(posedge i_clk)
    begin
        if (i_csr_valid)
        begin
            o_idx  <= i_csr_addr[7:0];
            o_data <= i_csr_operand;
        end
    end

endmodule

`default_nettype wire

// File: rtl/csr_field_reg.sv
`timescale 1ns/100ps
`default_nettype none

module csr_field_reg
    import csr_pkg::*;
#(
    parameter int WIDTH = 32
)
(
    input  wire logic      i_clk,
    input  wire logic      i_reset_n,
    input  wire logic      i_sel,
    input  wire logic      i_write,
    input  wire logic      i_set,
    input  wire logic      i_clear,
    input  csr_data_t      i_data,
    output csr_data_t      o_data
);

    logic [WIDTH-1:0] field_q;                      // Implemented bits only

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            field_q <= '0;
        else if (i_sel && i_write)
            field_q <= i_data[WIDTH-1:0];           // Upper operand bits dropped
        else if (i_sel && i_set)
            field_q <= field_q | i_data[WIDTH-1:0];
        else if (i_sel && i_clear)
            field_q <= field_q & ~i_data[WIDTH-1:0];
    end

    assign o_data = csr_data_t'(field_q);           // Zero-extend to 32 bits

endmodule

`default_nettype wire

// File: rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [31:0] csr_data_t;                // Register value
    typedef logic [11:0] csr_addr_t;                // Full CSR address
    typedef logic [7:0]  csr_idx_t;                 // Low index in machine block
    typedef logic [7:0]  cause_code_t;              // Exception or interrupt code
    typedef logic [11:0] irq_mask_t;                // Layout of mie and mip

    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,                        // Read only
        CSR_OP_RW    = 2'd1,                        // csrrw
        CSR_OP_SET   = 2'd2,                        // csrrs
        CSR_OP_CLEAR = 2'd3                         // csrrc
    } csr_op_e;

    localparam logic [3:0] CSR_ADDR_HI = 4'h3;      // Machine block 0x3xx

    localparam csr_idx_t IDX_MSTATUS    = 8'h00;
    localparam csr_idx_t IDX_MISA       = 8'h01;
    localparam csr_idx_t IDX_MIE        = 8'h04;
    localparam csr_idx_t IDX_MTVEC      = 8'h05;
    localparam csr_idx_t IDX_MCOUNTEREN = 8'h06;
    localparam csr_idx_t IDX_MSTATUSH   = 8'h10;
    localparam csr_idx_t IDX_MSCRATCH   = 8'h40;
    localparam csr_idx_t IDX_MEPC       = 8'h41;
    localparam csr_idx_t IDX_MCAUSE     = 8'h42;
    localparam csr_idx_t IDX_MTVAL      = 8'h43;
    localparam csr_idx_t IDX_MIP        = 8'h44;

    localparam logic EXT_C = 1'b1;                  // Compressed instructions

    // MXL=1 for RV32, plus I and optionally C
    localparam csr_data_t MISA_VALUE = (32'h1 << 30)
                                     | (32'h1 << 8)
                                     | (32'(EXT_C) << 2);

    localparam cause_code_t CAUSE_BREAKPOINT = 8'd3;
    localparam cause_code_t CAUSE_M_SOFT     = 8'd3;
    localparam cause_code_t CAUSE_M_TIMER    = 8'd7;
    localparam cause_code_t CAUSE_M_EXT      = 8'd11;

    localparam int MSTATUS_MIE_BIT  = 3;            // Global M-mode enable
    localparam int MSTATUS_MPIE_BIT = 7;            // Enable before trap

endpackage

`default_nettype wire
